/* hdl/panel_cfg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// panel configuration: matrix geometry, framebuffer address and
// write types, brightness mask
//////////////////////////////////////////////////////////////////////
package panel_cfg_pkg;

    localparam int PANEL_ROWS = 8;
    localparam int PANEL_COLS = 16;
    // red, green, blue
    localparam int PIXEL_BYTES = 3;
    localparam int BRIGHTNESS_LEVELS = 8;

    typedef logic [$clog2(PANEL_ROWS)-1:0] row_addr_t;
    typedef logic [$clog2(PANEL_COLS)-1:0] col_addr_t;
    typedef logic [$clog2(PIXEL_BYTES)-1:0] pixel_addr_t;

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        pixel_addr_t pixel;
    } fb_addr_t;

    typedef struct packed {
        logic valid;
        fb_addr_t addr;
        logic [7:0] data;
    } fb_write_t;

    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

endpackage

/* hdl/panel_cmd_pkg.sv */
//////////////////////////////////////////////////////////////////////
// command stream definitions: opcodes, controller states, input byte
//////////////////////////////////////////////////////////////////////
package panel_cmd_pkg;

    typedef enum logic [7:0] {
        RED_ENABLE        = 8'h10,
        RED_DISABLE       = 8'h11,
        GREEN_ENABLE      = 8'h12,
        GREEN_DISABLE     = 8'h13,
        BLUE_ENABLE       = 8'h14,
        BLUE_DISABLE      = 8'h15,
        // ONE..EIGHT toggle a single mask bit, msb first
        BRIGHTNESS_ZERO   = 8'h20,
        BRIGHTNESS_ONE    = 8'h21,
        BRIGHTNESS_TWO    = 8'h22,
        BRIGHTNESS_THREE  = 8'h23,
        BRIGHTNESS_FOUR   = 8'h24,
        BRIGHTNESS_FIVE   = 8'h25,
        BRIGHTNESS_SIX    = 8'h26,
        BRIGHTNESS_SEVEN  = 8'h27,
        BRIGHTNESS_EIGHT  = 8'h28,
        BRIGHTNESS_NINE   = 8'h29,
        READ_BRIGHTNESS   = 8'h30,
        BLANK_PANEL       = 8'h40,
        FILL_PANEL        = 8'h41,
        WRITE_PIXEL       = 8'h50
    } cmd_opcode_t;

    typedef enum logic [2:0] {
        STATE_IDLE,
        STATE_READ_BRIGHTNESS,
        STATE_BLANK_PANEL,
        STATE_FILL_PANEL,
        STATE_WRITE_PIXEL
    } ctrl_state_t;

    // take is high in the cycle the byte is transferred
    typedef struct packed {
        logic take;
        logic [7:0] data;
    } rx_byte_t;

endpackage

/* hdl/cmd_decoder.sv */
//////////////////////////////////////////////////////////////////////
// command decoder: opcode FSM, colour enables, brightness mask and
// selection of the active framebuffer engine
//////////////////////////////////////////////////////////////////////
module cmd_decoder (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      rx_valid,
    input  logic [7:0]                rx_data,
    input  logic                      pix_want_byte,
    input  logic                      pix_done,
    input  panel_cfg_pkg::fb_write_t  pix_wr,
    input  logic                      sweep_want_byte,
    input  logic                      sweep_done,
    input  panel_cfg_pkg::fb_write_t  sweep_wr,
    output logic                      rx_ready,
    output panel_cmd_pkg::rx_byte_t   rx_byte,
    output logic                      pix_start,
    output logic                      sweep_start,
    output logic                      sweep_blank,
    output panel_cfg_pkg::fb_write_t  fb_wr,
    output logic [2:0]                rgb_enable,
    output panel_cfg_pkg::brightness_t brightness,
    output logic                      busy
);
    import panel_cfg_pkg::*;
    import panel_cmd_pkg::*;

    ctrl_state_t state;
    cmd_opcode_t opcode;
    logic xfer;
    logic opcode_xfer;
    logic engine_active;
    brightness_t toggle_mask;

    assign opcode = cmd_opcode_t'(rx_data);
    assign xfer = rx_valid && rx_ready;
    assign opcode_xfer = xfer && (state == STATE_IDLE);

    // mask bit for BRIGHTNESS_ONE..EIGHT, level taken from the low nibble
    assign toggle_mask = brightness_t'(1) << (BRIGHTNESS_LEVELS - int'(rx_data[3:0]));

    assign engine_active = (state == STATE_WRITE_PIXEL) || (state == STATE_BLANK_PANEL)
                        || (state == STATE_FILL_PANEL);
    assign rx_byte.take = xfer && engine_active;
    assign rx_byte.data = rx_data;

    assign pix_start = opcode_xfer && (opcode == WRITE_PIXEL);
    assign sweep_start = opcode_xfer && ((opcode == BLANK_PANEL) || (opcode == FILL_PANEL));
    assign sweep_blank = (opcode == BLANK_PANEL);

    assign busy = (state != STATE_IDLE);

    // handshake and write go to whichever engine owns the state
    always_comb begin
        case (state)
            STATE_WRITE_PIXEL: begin
                rx_ready = pix_want_byte;
                fb_wr = pix_wr;
            end
            STATE_BLANK_PANEL, STATE_FILL_PANEL: begin
                rx_ready = sweep_want_byte;
                fb_wr = sweep_wr;
            end
            default: begin
                rx_ready = 1'b1;
                fb_wr = '0;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= STATE_IDLE;
            rgb_enable <= 3'b111;
            brightness <= '1;
        end else begin
            case (state)
                STATE_IDLE: begin
                    if (xfer) begin
                        case (opcode)
                            RED_ENABLE:      rgb_enable[0] <= 1'b1;
                            RED_DISABLE:     rgb_enable[0] <= 1'b0;
                            GREEN_ENABLE:    rgb_enable[1] <= 1'b1;
                            GREEN_DISABLE:   rgb_enable[1] <= 1'b0;
                            BLUE_ENABLE:     rgb_enable[2] <= 1'b1;
                            BLUE_DISABLE:    rgb_enable[2] <= 1'b0;
                            BRIGHTNESS_ZERO: brightness <= '0;
                            BRIGHTNESS_NINE: brightness <= '1;
                            BRIGHTNESS_ONE, BRIGHTNESS_TWO, BRIGHTNESS_THREE,
                            BRIGHTNESS_FOUR, BRIGHTNESS_FIVE, BRIGHTNESS_SIX,
                            BRIGHTNESS_SEVEN, BRIGHTNESS_EIGHT: begin
                                brightness <= brightness ^ toggle_mask;
                            end
                            READ_BRIGHTNESS: state <= STATE_READ_BRIGHTNESS;
                            BLANK_PANEL:     state <= STATE_BLANK_PANEL;
                            FILL_PANEL:      state <= STATE_FILL_PANEL;
                            WRITE_PIXEL:     state <= STATE_WRITE_PIXEL;
                            // unknown opcodes are dropped
                            default: begin
                            end
                        endcase
                    end
                end
                STATE_READ_BRIGHTNESS: begin
                    if (xfer) begin
                        brightness <= rx_data;
                        state <= STATE_IDLE;
                    end
                end
                STATE_WRITE_PIXEL: begin
                    if (pix_done) begin
                        state <= STATE_IDLE;
                    end
                end
                STATE_BLANK_PANEL, STATE_FILL_PANEL: begin
                    if (sweep_done) begin
                        state <= STATE_IDLE;
                    end
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

endmodule

/* hdl/pixel_writer.sv */
//////////////////////////////////////////////////////////////////////
// pixel writer: takes row, column and three colour bytes and writes
// one framebuffer byte per colour
//////////////////////////////////////////////////////////////////////
module pixel_writer (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  panel_cmd_pkg::rx_byte_t  rx_byte,
    output logic                     want_byte,
    output logic                     done,
    output panel_cfg_pkg::fb_write_t wr
);
    import panel_cfg_pkg::*;

    typedef enum logic [1:0] {
        PIX_IDLE,
        PIX_ROW,
        PIX_COL,
        PIX_COLOUR
    } pix_state_t;

    pix_state_t state;
    row_addr_t row;
    col_addr_t col;
    pixel_addr_t pixel;
    logic colour_take;
    logic last_byte;

    assign want_byte = (state != PIX_IDLE);
    assign colour_take = rx_byte.take && (state == PIX_COLOUR);
    assign last_byte = colour_take && (pixel == pixel_addr_t'(PIXEL_BYTES - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= PIX_IDLE;
            pixel <= '0;
        end else begin
            case (state)
                PIX_IDLE: begin
                    if (start) begin
                        state <= PIX_ROW;
                        pixel <= '0;
                    end
                end
                PIX_ROW: if (rx_byte.take) state <= PIX_COL;
                PIX_COL: if (rx_byte.take) state <= PIX_COLOUR;
                PIX_COLOUR: begin
                    if (colour_take) begin
                        pixel <= pixel + pixel_addr_t'(1);
                    end
                    if (last_byte) begin
                        state <= PIX_IDLE;
                    end
                end
                default: state <= PIX_IDLE;
            endcase
        end
    end

    // row and column wrap to the panel size
    always_ff @(posedge clk_in) begin
        if (rx_byte.take && (state == PIX_ROW)) begin
            row <= row_addr_t'(rx_byte.data);
        end
        if (rx_byte.take && (state == PIX_COL)) begin
            col <= col_addr_t'(rx_byte.data);
        end
    end

    // one registered write per colour byte
    always_ff @(posedge clk_in) begin
        if (reset) begin
            wr.valid <= 1'b0;
            done <= 1'b0;
        end else begin
            wr.valid <= colour_take;
            done <= last_byte;
        end
        if (colour_take) begin
            wr.addr <= '{row: row, col: col, pixel: pixel};
            wr.data <= rx_byte.data;
        end
    end

endmodule

/* hdl/panel_sweep.sv */
//////////////////////////////////////////////////////////////////////
// panel sweep: writes one colour, or zero for blank, to every
// framebuffer byte in row-major order
//////////////////////////////////////////////////////////////////////
module panel_sweep (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     blank,
    input  panel_cmd_pkg::rx_byte_t  rx_byte,
    output logic                     want_byte,
    output logic                     done,
    output panel_cfg_pkg::fb_write_t wr
);
    import panel_cfg_pkg::*;

    typedef enum logic [1:0] {
        SWEEP_IDLE,
        SWEEP_COLLECT,
        SWEEP_RUN
    } sweep_state_t;

    sweep_state_t state;
    row_addr_t row;
    col_addr_t col;
    pixel_addr_t pixel;
    logic [PIXEL_BYTES-1:0][7:0] colour;
    logic last_pixel;
    logic last_col;
    logic last_addr;

    assign want_byte = (state == SWEEP_COLLECT);
    assign last_pixel = (pixel == pixel_addr_t'(PIXEL_BYTES - 1));
    assign last_col = (col == col_addr_t'(PANEL_COLS - 1));
    assign last_addr = last_pixel && last_col && (row == row_addr_t'(PANEL_ROWS - 1));
    assign done = (state == SWEEP_RUN) && last_addr;

    always_comb begin
        wr.valid = (state == SWEEP_RUN);
        wr.addr = '{row: row, col: col, pixel: pixel};
        wr.data = colour[pixel];
    end

    // pixel doubles as colour byte index while collecting
    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= SWEEP_IDLE;
            row <= '0;
            col <= '0;
            pixel <= '0;
        end else begin
            case (state)
                SWEEP_IDLE: begin
                    if (start) begin
                        row <= '0;
                        col <= '0;
                        pixel <= '0;
                        state <= blank ? SWEEP_RUN : SWEEP_COLLECT;
                    end
                end
                SWEEP_COLLECT: begin
                    if (rx_byte.take) begin
                        pixel <= last_pixel ? '0 : pixel + pixel_addr_t'(1);
                        if (last_pixel) begin
                            state <= SWEEP_RUN;
                        end
                    end
                end
                SWEEP_RUN: begin
                    if (last_pixel) begin
                        pixel <= '0;
                        col <= last_col ? '0 : col + col_addr_t'(1);
                        if (last_col) begin
                            row <= row + row_addr_t'(1);
                        end
                    end else begin
                        pixel <= pixel + pixel_addr_t'(1);
                    end
                    if (last_addr) begin
                        state <= SWEEP_IDLE;
                    end
                end
                default: state <= SWEEP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (start && blank && (state == SWEEP_IDLE)) begin
            colour <= '0;
        end else if (rx_byte.take && (state == SWEEP_COLLECT)) begin
            colour[pixel] <= rx_byte.data;
        end
    end

endmodule

/* hdl/panel_controller.sv */
//////////////////////////////////////////////////////////////////////
// panel controller top: byte stream in, framebuffer writes and
// display settings out
//////////////////////////////////////////////////////////////////////
module panel_controller (
    input  logic                       clk_in,
    input  logic                       reset,
    input  logic                       rx_valid,
    input  logic [7:0]                 rx_data,
    output logic                       rx_ready,
    output panel_cfg_pkg::fb_write_t   fb_wr,
    output logic [2:0]                 rgb_enable,
    output panel_cfg_pkg::brightness_t brightness,
    output logic                       busy
);
    import panel_cfg_pkg::*;
    import panel_cmd_pkg::*;

    rx_byte_t rx_byte;
    logic pix_start;
    logic pix_want_byte;
    logic pix_done;
    fb_write_t pix_wr;
    logic sweep_start;
    logic sweep_blank;
    logic sweep_want_byte;
    logic sweep_done;
    fb_write_t sweep_wr;

    cmd_decoder decoder_i (
        .clk_in          (clk_in),
        .reset           (reset),
        .rx_valid        (rx_valid),
        .rx_data         (rx_data),
        .pix_want_byte   (pix_want_byte),
        .pix_done        (pix_done),
        .pix_wr          (pix_wr),
        .sweep_want_byte (sweep_want_byte),
        .sweep_done      (sweep_done),
        .sweep_wr        (sweep_wr),
        .rx_ready        (rx_ready),
        .rx_byte         (rx_byte),
        .pix_start       (pix_start),
        .sweep_start     (sweep_start),
        .sweep_blank     (sweep_blank),
        .fb_wr           (fb_wr),
        .rgb_enable      (rgb_enable),
        .brightness      (brightness),
        .busy            (busy)
    );

    pixel_writer pixel_writer_i (
        .clk_in    (clk_in),
        .reset     (reset),
        .start     (pix_start),
        .rx_byte   (rx_byte),
        .want_byte (pix_want_byte),
        .done      (pix_done),
        .wr        (pix_wr)
    );

    panel_sweep panel_sweep_i (
        .clk_in    (clk_in),
        .reset     (reset),
        .start     (sweep_start),
        .blank     (sweep_blank),
        .rx_byte   (rx_byte),
        .want_byte (sweep_want_byte),
        .done      (sweep_done),
        .wr        (sweep_wr)
    );

endmodule

/* dv/panel_controller_properties.sv */
//////////////////////////////////////////////////////////////////////
// panel controller properties: write address range, settings update
// timing and input stall during a sweep
//////////////////////////////////////////////////////////////////////
module panel_controller_properties (
    input logic                       clk_in,
    input logic                       reset,
    input logic                       rx_valid,
    input logic                       rx_ready,
    input panel_cfg_pkg::fb_write_t   fb_wr,
    input panel_cfg_pkg::fb_write_t   sweep_wr,
    input logic [2:0]                 rgb_enable,
    input panel_cfg_pkg::brightness_t brightness,
    input logic                       busy
);
    timeunit 1ns;
    timeprecision 1ps;
    import panel_cfg_pkg::*;

    logic xfer;

    assign xfer = rx_valid && rx_ready;

    write_in_range: assert property (@(posedge clk_in) disable iff (reset)
        fb_wr.valid |-> (int'(fb_wr.addr.row) < PANEL_ROWS)
                     && (int'(fb_wr.addr.col) < PANEL_COLS)
                     && (int'(fb_wr.addr.pixel) < PIXEL_BYTES))
        else $error("framebuffer write outside the panel geometry");

    // a settings change must follow a byte transfer by one cycle
    settings_after_xfer: assert property (@(posedge clk_in) disable iff (reset)
        !$stable({rgb_enable, brightness}) |-> $past(xfer))
        else $error("rgb_enable or brightness changed without a transfer");

    sweep_stalls_input: assert property (@(posedge clk_in) disable iff (reset)
        (busy && sweep_wr.valid) |-> !rx_ready)
        else $error("rx_ready high during a panel sweep");

endmodule

bind panel_controller panel_controller_properties props_i (
    .clk_in     (clk_in),
    .reset      (reset),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .fb_wr      (fb_wr),
    .sweep_wr   (sweep_wr),
    .rgb_enable (rgb_enable),
    .brightness (brightness),
    .busy       (busy)
);

/* dv/panel_controller_tb.sv */
//////////////////////////////////////////////////////////////////////
// panel controller testbench: random command stream checked against
// a model of the settings registers and the framebuffer
//////////////////////////////////////////////////////////////////////
module panel_controller_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import panel_cfg_pkg::*;
    import panel_cmd_pkg::*;

    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT = 1000;
    localparam int NUM_COMMANDS = 60;

    logic clk_in = 1'b0;
    logic reset;
    logic rx_valid;
    logic [7:0] rx_data;
    logic rx_ready;
    fb_write_t fb_wr;
    logic [2:0] rgb_enable;
    brightness_t brightness;
    logic busy;

    logic [31:0] lfsr = 32'h156a_6ff8;
    fb_write_t expected_writes [$];
    logic [7:0] model_fb [PANEL_ROWS][PANEL_COLS][PIXEL_BYTES];
    logic [7:0] dut_fb [PANEL_ROWS][PANEL_COLS][PIXEL_BYTES];
    logic [2:0] model_rgb;
    brightness_t model_brightness;

    cmd_opcode_t opcode_table [20] = '{
        RED_ENABLE, RED_DISABLE, GREEN_ENABLE, GREEN_DISABLE, BLUE_ENABLE, BLUE_DISABLE,
        BRIGHTNESS_ZERO, BRIGHTNESS_ONE, BRIGHTNESS_TWO, BRIGHTNESS_THREE, BRIGHTNESS_FOUR,
        BRIGHTNESS_FIVE, BRIGHTNESS_SIX, BRIGHTNESS_SEVEN, BRIGHTNESS_EIGHT, BRIGHTNESS_NINE,
        READ_BRIGHTNESS, BLANK_PANEL, FILL_PANEL, WRITE_PIXEL
    };

    panel_controller dut_i (
        .clk_in     (clk_in),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_ready   (rx_ready),
        .fb_wr      (fb_wr),
        .rgb_enable (rgb_enable),
        .brightness (brightness),
        .busy       (busy)
    );

    always #50 clk_in = ~clk_in;

    // galois lfsr, stepped once per bit taken
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_write(input fb_write_t exp, input fb_write_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t fb_wr expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_brightness(input brightness_t exp, input brightness_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t brightness expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_rgb(input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t rgb_enable expected %b actual %b", $time, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    task automatic check_fb_byte(input int r, input int c, input int p);
        if (dut_fb[r][c][p] !== model_fb[r][c][p]) begin
            fail_now($sformatf("ERR %0t framebuffer[%0d][%0d][%0d] expected %h actual %h",
                $time, r, c, p, model_fb[r][c][p], dut_fb[r][c][p]));
        end
    endtask

    task automatic expect_write(input int r, input int c, input int p, input logic [7:0] data);
        fb_write_t w;
        w.valid = 1'b1;
        w.addr.row = row_addr_t'(r);
        w.addr.col = col_addr_t'(c);
        w.addr.pixel = pixel_addr_t'(p);
        w.data = data;
        expected_writes.push_back(w);
        model_fb[r][c][p] = data;
    endtask

    // offer one byte and hold it until the DUT takes it
    task automatic send_byte(input logic [7:0] value);
        int cycles;
        cycles = 0;
        rx_valid = 1'b1;
        rx_data = value;
        @(negedge clk_in);
        while (!rx_ready) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout: a pending byte was never taken");
            end
            @(negedge clk_in);
        end
        @(posedge clk_in);
        #DRIVE_DELAY;
        rx_valid = 1'b0;
    endtask

    task automatic run_command(input cmd_opcode_t op);
        logic [7:0] row_byte;
        logic [7:0] col_byte;
        logic [7:0] colour [PIXEL_BYTES];
        logic [7:0] arg;
        int level;
        send_byte(op);
        if (expected_writes.size() != 0) begin
            fail_now("an opcode was taken while the previous command was still writing");
        end
        check_flag("busy", (op == READ_BRIGHTNESS) || (op == WRITE_PIXEL)
            || (op == FILL_PANEL) || (op == BLANK_PANEL), busy);
        case (op)
            RED_ENABLE:      model_rgb[0] = 1'b1;
            RED_DISABLE:     model_rgb[0] = 1'b0;
            GREEN_ENABLE:    model_rgb[1] = 1'b1;
            GREEN_DISABLE:   model_rgb[1] = 1'b0;
            BLUE_ENABLE:     model_rgb[2] = 1'b1;
            BLUE_DISABLE:    model_rgb[2] = 1'b0;
            BRIGHTNESS_ZERO: model_brightness = '0;
            BRIGHTNESS_NINE: model_brightness = '1;
            BRIGHTNESS_ONE, BRIGHTNESS_TWO, BRIGHTNESS_THREE, BRIGHTNESS_FOUR,
            BRIGHTNESS_FIVE, BRIGHTNESS_SIX, BRIGHTNESS_SEVEN, BRIGHTNESS_EIGHT: begin
                // level n flips mask bit BRIGHTNESS_LEVELS - n
                level = int'(op) - int'(BRIGHTNESS_ZERO);
                model_brightness[BRIGHTNESS_LEVELS - level] =
                    ~model_brightness[BRIGHTNESS_LEVELS - level];
            end
            READ_BRIGHTNESS: begin
                arg = random_bits(8);
                send_byte(arg);
                model_brightness = arg;
            end
            WRITE_PIXEL: begin
                row_byte = random_bits(8);
                col_byte = random_bits(8);
                for (int p = 0; p < PIXEL_BYTES; p++) begin
                    colour[p] = random_bits(8);
                    expect_write(int'(row_byte) % PANEL_ROWS, int'(col_byte) % PANEL_COLS,
                        p, colour[p]);
                end
                send_byte(row_byte);
                send_byte(col_byte);
                for (int p = 0; p < PIXEL_BYTES; p++) begin
                    send_byte(colour[p]);
                end
            end
            FILL_PANEL, BLANK_PANEL: begin
                for (int p = 0; p < PIXEL_BYTES; p++) begin
                    colour[p] = (op == FILL_PANEL) ? random_bits(8) : 8'h00;
                end
                for (int r = 0; r < PANEL_ROWS; r++) begin
                    for (int c = 0; c < PANEL_COLS; c++) begin
                        for (int p = 0; p < PIXEL_BYTES; p++) begin
                            expect_write(r, c, p, colour[p]);
                        end
                    end
                end
                if (op == FILL_PANEL) begin
                    for (int p = 0; p < PIXEL_BYTES; p++) begin
                        send_byte(colour[p]);
                    end
                end
            end
        endcase
        check_rgb(model_rgb, rgb_enable);
        check_brightness(model_brightness, brightness);
    endtask

    // every write is checked as it appears and copied into the DUT image
    always @(negedge clk_in) begin
        fb_write_t exp;
        if (!reset && fb_wr.valid) begin
            if (expected_writes.size() == 0) begin
                fail_now("framebuffer write appeared with no write expected");
            end else begin
                exp = expected_writes.pop_front();
                check_write(exp, fb_wr);
                check_flag("busy", 1'b1, busy);
                dut_fb[fb_wr.addr.row][fb_wr.addr.col][fb_wr.addr.pixel] = fb_wr.data;
            end
        end
    end

    initial begin
        int cycles;
        int idx;
        reset = 1'b1;
        rx_valid = 1'b0;
        rx_data = 8'h00;
        model_rgb = 3'b111;
        model_brightness = '1;
        for (int r = 0; r < PANEL_ROWS; r++) begin
            for (int c = 0; c < PANEL_COLS; c++) begin
                for (int p = 0; p < PIXEL_BYTES; p++) begin
                    idx = (r * PANEL_COLS + c) * PIXEL_BYTES + p;
                    model_fb[r][c][p] = 8'(idx) ^ 8'(idx >> 8) ^ 8'h3c;
                    dut_fb[r][c][p] = model_fb[r][c][p];
                end
            end
        end
        repeat (5) @(posedge clk_in);
        #DRIVE_DELAY;
        reset = 1'b0;
        @(negedge clk_in);
        check_rgb(3'b111, rgb_enable);
        check_brightness('1, brightness);
        check_flag("busy", 1'b0, busy);
        check_flag("rx_ready", 1'b1, rx_ready);
        check_flag("fb_wr.valid", 1'b0, fb_wr.valid);
        @(posedge clk_in);
        #DRIVE_DELAY;

        run_command(FILL_PANEL);
        run_command(WRITE_PIXEL);
        run_command(BLANK_PANEL);
        for (int i = 0; i < NUM_COMMANDS; i++) begin
            run_command(opcode_table[int'(random_bits(5)) % 20]);
        end

        cycles = 0;
        while ((expected_writes.size() != 0) || busy) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout: last command never finished its writes");
            end
            @(negedge clk_in);
        end
        for (int r = 0; r < PANEL_ROWS; r++) begin
            for (int c = 0; c < PANEL_COLS; c++) begin
                for (int p = 0; p < PIXEL_BYTES; p++) begin
                    check_fb_byte(r, c, p);
                end
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

/* panel_controller.f */
hdl/panel_cfg_pkg.sv
hdl/panel_cmd_pkg.sv
hdl/cmd_decoder.sv
hdl/pixel_writer.sv
hdl/panel_sweep.sv
hdl/panel_controller.sv
dv/panel_controller_properties.sv
dv/panel_controller_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module panel_controller_tb -f panel_controller.f -o Vpanel_controller_tb

status=0
out=$(./obj_dir/Vpanel_controller_tb 2>&1) || status=$?
echo "$out"
echo "simulator exit status: $status"
echo "$out" | grep -qx "Test passed"
